// File: stbuf_cfg.svh
// store buffer configuration: depth and the address, data and byte widths

`ifndef STBUF_CFG_SVH
`define STBUF_CFG_SVH

// ---------------------------------------------------------------------------
// buffer geometry
// ---------------------------------------------------------------------------

// number of entries, power of two
`define STBUF_DEPTH 4

// stored byte address width
`define STBUF_ADDR_BITS 16

// ---------------------------------------------------------------------------
// data lane
// ---------------------------------------------------------------------------

`define STBUF_DATA_WIDTH 32   // one memory word per entry

// bytes per entry, data width over eight
`define STBUF_BYTE_WIDTH 4

`endif

// File: stbuf_pkg.sv
// store buffer package: entry states, access sizes and width-derived types
`default_nettype none

`include "stbuf_cfg.svh"

package stbuf_pkg;

   // lifecycle of one buffer entry
   typedef enum logic [1:0] {
      ent_free,    // slot unused
      ent_wait,    // written in dc3, decision pending in dc5
      ent_drain,   // committed, goes to memory
      ent_flush    // killed, dropped at the head
   } stbuf_ent_e;

   typedef enum logic [1:0] {
      sz_byte,
      sz_half,
      sz_word
   } ldst_size_e;

   typedef logic [$clog2(`STBUF_DEPTH)-1:0] stbuf_ptr_t;
   typedef logic [`STBUF_ADDR_BITS-1:0]     stbuf_addr_t;
   typedef logic [`STBUF_DATA_WIDTH-1:0]    stbuf_data_t;
   typedef logic [`STBUF_BYTE_WIDTH-1:0]    stbuf_byteen_t;

endpackage

`default_nettype wire

// File: stbuf_alloc.sv
// store buffer allocation: write pointer, byte enables and the dc3 to dc5 pipe
`timescale 1ns/10ps
`default_nettype none

`include "stbuf_cfg.svh"

module stbuf_alloc
   import stbuf_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,

   input  logic          store_valid_dc3,
   input  stbuf_addr_t   store_addr_dc3,
   input  ldst_size_e    store_size_dc3,
   input  stbuf_data_t   store_data_dc3,

   output logic          wr_en,
   output stbuf_ptr_t    wr_ptr,
   output stbuf_addr_t   wr_addr,
   output stbuf_byteen_t wr_byteen,
   output stbuf_data_t   wr_data,

   output logic          dc5_valid,
   output stbuf_ptr_t    dc5_ptr
);

   localparam int BYTE_OFS = $clog2(`STBUF_BYTE_WIDTH);

   stbuf_byteen_t size_mask;
   logic          dc4_valid;
   stbuf_ptr_t    dc4_ptr;

   // ------------------------------------------------------------------------
   // byte enables
   // ------------------------------------------------------------------------
   always_comb begin
      case (store_size_dc3)
         sz_byte: size_mask = stbuf_byteen_t'(1);
         sz_half: size_mask = stbuf_byteen_t'(3);
         default: size_mask = '1;           // full word
      endcase
   end

   // lanes above the word are dropped, no second bank
   assign wr_byteen = size_mask << store_addr_dc3[BYTE_OFS-1:0];

   assign wr_en   = store_valid_dc3;
   assign wr_addr = store_addr_dc3;
   assign wr_data = store_data_dc3;

   // ------------------------------------------------------------------------
   // write pointer and dc4/dc5 tracking
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         dc4_valid <= 1'b0;
         dc4_ptr   <= '0;
         dc5_valid <= 1'b0;
         dc5_ptr   <= '0;
      end else begin
         if (store_valid_dc3) begin
            wr_ptr <= wr_ptr + 1'b1;        // wraps with depth
         end
         dc4_valid <= store_valid_dc3;
         dc4_ptr   <= wr_ptr;              // slot taken in dc3
         dc5_valid <= dc4_valid;
         dc5_ptr   <= dc4_ptr;
      end
   end

endmodule

`default_nettype wire

// File: stbuf_entries.sv
// store buffer entries: storage, entry state, read pointer, drain and occupancy
`timescale 1ns/10ps
`default_nettype none

`include "stbuf_cfg.svh"

module stbuf_entries
   import stbuf_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,

   input  logic          wr_en,
   input  stbuf_ptr_t    wr_ptr,
   input  stbuf_addr_t   wr_addr,
   input  stbuf_byteen_t wr_byteen,
   input  stbuf_data_t   wr_data,

   input  logic          dc5_valid,
   input  stbuf_ptr_t    dc5_ptr,
   input  logic          commit_dc5,

   input  logic          isldst_dc1,
   input  logic          ldst_dc2,
   input  logic          ldst_dc3,

   input  logic          drain_done,
   output logic          drain_req,
   output logic          drain_flushed,
   output stbuf_addr_t   drain_addr,
   output stbuf_byteen_t drain_byteen,
   output stbuf_data_t   drain_data,

   output logic          stbuf_full,
   output logic          stbuf_empty,

   output stbuf_addr_t   [`STBUF_DEPTH-1:0] ent_addr,
   output stbuf_byteen_t [`STBUF_DEPTH-1:0] ent_byteen,
   output stbuf_data_t   [`STBUF_DEPTH-1:0] ent_data,
   output logic          [`STBUF_DEPTH-1:0] ent_fwd_vld
);

   localparam int DEPTH = `STBUF_DEPTH;
   localparam int CNT_W = $clog2(`STBUF_DEPTH) + 2;

   stbuf_ent_e        ent_state     [DEPTH];
   stbuf_ent_e        ent_state_nxt [DEPTH];
   logic [DEPTH-1:0]  ent_occ;
   stbuf_ptr_t        rd_ptr;
   logic              pop;
   logic [CNT_W-1:0]  num_vld;
   logic [CNT_W-1:0]  spec_vld;

   // ------------------------------------------------------------------------
   // head of buffer
   // ------------------------------------------------------------------------
   assign drain_req     = (ent_state[rd_ptr] == ent_drain);
   assign drain_flushed = (ent_state[rd_ptr] == ent_flush);
   assign drain_addr    = ent_addr[rd_ptr];
   assign drain_byteen  = ent_byteen[rd_ptr];
   assign drain_data    = ent_data[rd_ptr];

   // flushed head leaves without memory
   assign pop = (drain_req & drain_done) | drain_flushed;

   // ------------------------------------------------------------------------
   // entry state
   // ------------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         ent_state_nxt[i] = ent_state[i];
         if (pop && (rd_ptr == stbuf_ptr_t'(i))) begin
            ent_state_nxt[i] = ent_free;
         end
         if (dc5_valid && (dc5_ptr == stbuf_ptr_t'(i)) && (ent_state[i] == ent_wait)) begin
            ent_state_nxt[i] = commit_dc5 ? ent_drain : ent_flush;
         end
         if (wr_en && (wr_ptr == stbuf_ptr_t'(i))) begin
            ent_state_nxt[i] = ent_wait;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            ent_state[i] <= ent_free;
         end
         rd_ptr <= '0;
      end else begin
         ent_state <= ent_state_nxt;
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // payload, only the slot at wr_ptr loads
   always_ff @(posedge clk) begin
      if (wr_en) begin
         ent_addr[wr_ptr]   <= wr_addr;
         ent_byteen[wr_ptr] <= wr_byteen;
         ent_data[wr_ptr]   <= wr_data;
      end
   end

   // ------------------------------------------------------------------------
   // occupancy
   // ------------------------------------------------------------------------
   always_comb begin
      num_vld = '0;
      for (int i = 0; i < DEPTH; i++) begin
         ent_occ[i]     = (ent_state[i] != ent_free);
         ent_fwd_vld[i] = ent_occ[i] && (ent_state[i] != ent_flush);
         num_vld        = num_vld + CNT_W'(ent_occ[i]);
      end
   end

   // in-flight memory ops may each need a slot
   assign spec_vld = num_vld + CNT_W'(isldst_dc1) + CNT_W'(ldst_dc2) + CNT_W'(ldst_dc3);

   assign stbuf_full  = (spec_vld >= CNT_W'(DEPTH));
   assign stbuf_empty = ~(|ent_occ);

endmodule

`default_nettype wire

// File: stbuf_fwd.sv
// store buffer load forwarding: youngest-wins byte merge registered into dc3
`timescale 1ns/10ps
`default_nettype none

`include "stbuf_cfg.svh"

module stbuf_fwd
   import stbuf_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,

   input  logic          load_cmpen_dc2,
   input  stbuf_addr_t   load_addr_dc2,

   input  logic          wr_en,
   input  stbuf_ptr_t    wr_ptr,
   input  stbuf_addr_t   wr_addr,
   input  stbuf_byteen_t wr_byteen,
   input  stbuf_data_t   wr_data,

   input  stbuf_addr_t   [`STBUF_DEPTH-1:0] ent_addr,
   input  stbuf_byteen_t [`STBUF_DEPTH-1:0] ent_byteen,
   input  stbuf_data_t   [`STBUF_DEPTH-1:0] ent_data,
   input  logic          [`STBUF_DEPTH-1:0] ent_fwd_vld,

   output stbuf_data_t   fwd_data_dc3,
   output stbuf_byteen_t fwd_byteen_dc3
);

   localparam int DEPTH    = `STBUF_DEPTH;
   localparam int BW       = `STBUF_BYTE_WIDTH;
   localparam int AW       = `STBUF_ADDR_BITS;
   localparam int BYTE_OFS = $clog2(`STBUF_BYTE_WIDTH);

   stbuf_data_t   fwd_data_dc2;
   stbuf_byteen_t fwd_byteen_dc2;

   // same word, byte offset ignored
   function automatic logic word_match(stbuf_addr_t a, stbuf_addr_t b);
      return a[AW-1:BYTE_OFS] == b[AW-1:BYTE_OFS];
   endfunction

   // ------------------------------------------------------------------------
   // dc2 merge
   // ------------------------------------------------------------------------
   always_comb begin : merge
      stbuf_ptr_t idx;
      logic       hit;

      fwd_data_dc2   = '0;
      fwd_byteen_dc2 = '0;

      // oldest first, the slot at wr_ptr is the oldest one
      for (int i = 0; i < DEPTH; i++) begin
         idx = wr_ptr + stbuf_ptr_t'(i);
         hit = load_cmpen_dc2 && ent_fwd_vld[idx] && word_match(ent_addr[idx], load_addr_dc2);
         for (int j = 0; j < BW; j++) begin
            if (hit && ent_byteen[idx][j]) begin
               fwd_byteen_dc2[j]       = 1'b1;
               fwd_data_dc2[8*j +: 8] = ent_data[idx][8*j +: 8];
            end
         end
      end

      // store in dc3 is younger than any entry
      hit = load_cmpen_dc2 && wr_en && word_match(wr_addr, load_addr_dc2);
      for (int j = 0; j < BW; j++) begin
         if (hit && wr_byteen[j]) begin
            fwd_byteen_dc2[j]       = 1'b1;
            fwd_data_dc2[8*j +: 8] = wr_data[8*j +: 8];
         end
      end
   end

   // ------------------------------------------------------------------------
   // dc3 result
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fwd_byteen_dc3 <= '0;
         fwd_data_dc3   <= '0;
      end else begin
         fwd_byteen_dc3 <= fwd_byteen_dc2;
         fwd_data_dc3   <= fwd_data_dc2;   // zero where not enabled
      end
   end

endmodule

`default_nettype wire

// File: stbuf_top.sv
// store buffer top level joining allocation, entry storage and load forwarding
`timescale 1ns/10ps
`default_nettype none

`include "stbuf_cfg.svh"

module stbuf_top
   import stbuf_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,

   // store in dc3
   input  logic          store_valid_dc3,
   input  stbuf_addr_t   store_addr_dc3,
   input  ldst_size_e    store_size_dc3,
   input  stbuf_data_t   store_data_dc3,

   input  logic          isldst_dc1,
   input  logic          ldst_dc2,
   input  logic          ldst_dc3,
   input  logic          commit_dc5,

   // load compare in dc2
   input  logic          load_cmpen_dc2,
   input  stbuf_addr_t   load_addr_dc2,

   // memory drain port
   input  logic          drain_done,
   output logic          drain_req,
   output logic          drain_flushed,
   output stbuf_addr_t   drain_addr,
   output stbuf_byteen_t drain_byteen,
   output stbuf_data_t   drain_data,

   output logic          stbuf_full,
   output logic          stbuf_empty,

   output stbuf_data_t   fwd_data_dc3,
   output stbuf_byteen_t fwd_byteen_dc3
);

   logic                               wr_en;
   stbuf_ptr_t                         wr_ptr;
   stbuf_addr_t                        wr_addr;
   stbuf_byteen_t                      wr_byteen;
   stbuf_data_t                        wr_data;
   logic                               dc5_valid;
   stbuf_ptr_t                         dc5_ptr;
   stbuf_addr_t   [`STBUF_DEPTH-1:0]   ent_addr;
   stbuf_byteen_t [`STBUF_DEPTH-1:0]   ent_byteen;
   stbuf_data_t   [`STBUF_DEPTH-1:0]   ent_data;
   logic          [`STBUF_DEPTH-1:0]   ent_fwd_vld;

   stbuf_alloc u_alloc (
      .clk             (clk),
      .rst_n           (rst_n),
      .store_valid_dc3 (store_valid_dc3),
      .store_addr_dc3  (store_addr_dc3),
      .store_size_dc3  (store_size_dc3),
      .store_data_dc3  (store_data_dc3),
      .wr_en           (wr_en),
      .wr_ptr          (wr_ptr),
      .wr_addr         (wr_addr),
      .wr_byteen       (wr_byteen),
      .wr_data         (wr_data),
      .dc5_valid       (dc5_valid),
      .dc5_ptr         (dc5_ptr)
   );

   stbuf_entries u_entries (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_en         (wr_en),
      .wr_ptr        (wr_ptr),
      .wr_addr       (wr_addr),
      .wr_byteen     (wr_byteen),
      .wr_data       (wr_data),
      .dc5_valid     (dc5_valid),
      .dc5_ptr       (dc5_ptr),
      .commit_dc5    (commit_dc5),
      .isldst_dc1    (isldst_dc1),
      .ldst_dc2      (ldst_dc2),
      .ldst_dc3      (ldst_dc3),
      .drain_done    (drain_done),
      .drain_req     (drain_req),
      .drain_flushed (drain_flushed),
      .drain_addr    (drain_addr),
      .drain_byteen  (drain_byteen),
      .drain_data    (drain_data),
      .stbuf_full    (stbuf_full),
      .stbuf_empty   (stbuf_empty),
      .ent_addr      (ent_addr),
      .ent_byteen    (ent_byteen),
      .ent_data      (ent_data),
      .ent_fwd_vld   (ent_fwd_vld)
   );

   stbuf_fwd u_fwd (
      .clk            (clk),
      .rst_n          (rst_n),
      .load_cmpen_dc2 (load_cmpen_dc2),
      .load_addr_dc2  (load_addr_dc2),
      .wr_en          (wr_en),
      .wr_ptr         (wr_ptr),
      .wr_addr        (wr_addr),
      .wr_byteen      (wr_byteen),
      .wr_data        (wr_data),
      .ent_addr       (ent_addr),
      .ent_byteen     (ent_byteen),
      .ent_data       (ent_data),
      .ent_fwd_vld    (ent_fwd_vld),
      .fwd_data_dc3   (fwd_data_dc3),
      .fwd_byteen_dc3 (fwd_byteen_dc3)
   );

endmodule

`default_nettype wire

// File: tb_stbuf.sv
// store buffer testbench checking a random store and load stream against a program-order model
`timescale 1ns/10ps
`default_nettype none

`include "stbuf_cfg.svh"

module tb_stbuf
   import stbuf_pkg::*;
();

   localparam int NUM_STORES  = 300;
   localparam int WDOG_CYCLES = 60 * NUM_STORES;

   typedef struct packed {
      logic [31:0]   seq;
      stbuf_addr_t   addr;
      stbuf_byteen_t be;
      stbuf_data_t   data;
      logic [1:0]    st;       // 0 waiting, 1 committed, 2 flushed
   } model_ent_t;

   logic          clk = 1'b0;
   logic          rst_n;
   logic          store_valid_dc3;
   stbuf_addr_t   store_addr_dc3;
   ldst_size_e    store_size_dc3;
   stbuf_data_t   store_data_dc3;
   logic          isldst_dc1;
   logic          ldst_dc2;
   logic          ldst_dc3;
   logic          commit_dc5;
   logic          load_cmpen_dc2;
   stbuf_addr_t   load_addr_dc2;
   logic          drain_done;
   logic          drain_req;
   logic          drain_flushed;
   stbuf_addr_t   drain_addr;
   stbuf_byteen_t drain_byteen;
   stbuf_data_t   drain_data;
   logic          stbuf_full;
   logic          stbuf_empty;
   stbuf_data_t   fwd_data_dc3;
   stbuf_byteen_t fwd_byteen_dc3;

   // instruction pipe dc1..dc3 with kind 0 none, 1 load, 2 store
   logic [1:0]    pk [1:3];
   stbuf_addr_t   pa [1:3];
   ldst_size_e    ps [1:3];
   stbuf_data_t   pd [1:3];

   model_ent_t    model_q [$];
   logic          p1_v = 1'b0;
   logic          p2_v = 1'b0;
   logic [31:0]   p1_seq = '0;
   logic [31:0]   p2_seq = '0;
   int unsigned   store_seq = 0;
   stbuf_byteen_t exp_fwd_be = '0;
   stbuf_data_t   exp_fwd_data = '0;
   logic          full_seen = 1'b0;
   int            n_issued = 0;
   int            n_errors = 0;
   int            n_checks = 0;
   int            n_drained = 0;
   int            n_flushed = 0;

   stbuf_top i_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .store_valid_dc3 (store_valid_dc3),
      .store_addr_dc3  (store_addr_dc3),
      .store_size_dc3  (store_size_dc3),
      .store_data_dc3  (store_data_dc3),
      .isldst_dc1      (isldst_dc1),
      .ldst_dc2        (ldst_dc2),
      .ldst_dc3        (ldst_dc3),
      .commit_dc5      (commit_dc5),
      .load_cmpen_dc2  (load_cmpen_dc2),
      .load_addr_dc2   (load_addr_dc2),
      .drain_done      (drain_done),
      .drain_req       (drain_req),
      .drain_flushed   (drain_flushed),
      .drain_addr      (drain_addr),
      .drain_byteen    (drain_byteen),
      .drain_data      (drain_data),
      .stbuf_full      (stbuf_full),
      .stbuf_empty     (stbuf_empty),
      .fwd_data_dc3    (fwd_data_dc3),
      .fwd_byteen_dc3  (fwd_byteen_dc3)
   );

   always #5 clk = ~clk;

   // -------------------------------------------------------------------------
   // reference rules
   // -------------------------------------------------------------------------
   function automatic stbuf_byteen_t lane_mask(ldst_size_e size, stbuf_addr_t addr);
      logic [7:0] m;
      case (size)
         sz_byte: m = 8'h01;
         sz_half: m = 8'h03;
         default: m = 8'h0f;
      endcase
      m = m << addr[1:0];
      return m[`STBUF_BYTE_WIDTH-1:0];     // upper lanes fall off
   endfunction

   function automatic logic same_word(stbuf_addr_t a, stbuf_addr_t b);
      return a[`STBUF_ADDR_BITS-1:2] == b[`STBUF_ADDR_BITS-1:2];
   endfunction

   // newer bytes replace older ones lane by lane
   function automatic stbuf_data_t overlay(stbuf_data_t d, stbuf_data_t n, stbuf_byteen_t be);
      for (int j = 0; j < `STBUF_BYTE_WIDTH; j++) begin
         if (be[j]) begin
            d[8*j +: 8] = n[8*j +: 8];
         end
      end
      return d;
   endfunction

   task automatic report_mismatch(input string msg);
      n_errors++;
      $display("mismatch at %0d ns: %s", $time, msg);
   endtask

   task automatic print_summary();
      $display("summary: %0d cycles checked, %0d errors, %0d drained, %0d flushed",
               n_checks, n_errors, n_drained, n_flushed);
   endtask

   // -------------------------------------------------------------------------
   // stimulus with one call per rising edge
   // -------------------------------------------------------------------------
   task automatic drive_cycle(input logic allow_new);
      int unsigned word;
      int unsigned off;
      for (int i = 3; i > 1; i--) begin
         pk[i] = pk[i-1];
         pa[i] = pa[i-1];
         ps[i] = ps[i-1];
         pd[i] = pd[i-1];
      end
      pk[1] = 2'd0;
      // no new op while the previous cycle reported full
      if (allow_new && !full_seen && (($urandom % 100) < 70)) begin
         pk[1] = (($urandom % 2) == 0) ? 2'd2 : 2'd1;
         ps[1] = ldst_size_e'(2'($urandom % 3));
         word  = $urandom % 4;               // few words, many hits
         off   = $urandom % 4;
         if (ps[1] == sz_half) begin
            off = off & 2;
         end else if (ps[1] == sz_word) begin
            off = 0;
         end
         pa[1] = stbuf_addr_t'(32'h400 + word * 4 + off);
         pd[1] = stbuf_data_t'($urandom);
         if (pk[1] == 2'd2) begin
            n_issued++;
         end
      end
      isldst_dc1      <= (pk[1] != 2'd0);
      ldst_dc2        <= (pk[2] != 2'd0);
      ldst_dc3        <= (pk[3] != 2'd0);
      load_cmpen_dc2  <= (pk[2] == 2'd1);
      load_addr_dc2   <= pa[2];
      store_valid_dc3 <= (pk[3] == 2'd2);
      store_addr_dc3  <= pa[3];
      store_size_dc3  <= ps[3];
      store_data_dc3  <= pd[3];
      commit_dc5      <= (($urandom % 4) != 0);   // mostly commits
      drain_done      <= (($urandom % 5) < 2);    // back-pressure
   endtask

   // -------------------------------------------------------------------------
   // checker and model step at the falling edge where outputs are stable
   // -------------------------------------------------------------------------
   always @(negedge clk) begin : check_cycle
      logic          exp_req;
      logic          exp_flush;
      logic          exp_full;
      int            inflight;
      stbuf_byteen_t nbe;
      stbuf_data_t   ndata;
      model_ent_t    ent;
      if (rst_n) begin
         n_checks++;
         exp_req   = 1'b0;
         exp_flush = 1'b0;
         if (model_q.size() > 0) begin
            ent       = model_q[0];
            exp_req   = (ent.st == 2'd1);
            exp_flush = (ent.st == 2'd2);
         end
         assert (drain_req == exp_req)
            else report_mismatch($sformatf("drain_req %0b, expected %0b", drain_req, exp_req));
         assert (drain_flushed == exp_flush)
            else report_mismatch($sformatf("drain_flushed %0b, expected %0b",
                                           drain_flushed, exp_flush));
         if (exp_req) begin
            assert (drain_addr == ent.addr)
               else report_mismatch($sformatf("drain_addr %h, expected %h", drain_addr, ent.addr));
            assert (drain_byteen == ent.be)
               else report_mismatch($sformatf("drain_byteen %h, expected %h",
                                              drain_byteen, ent.be));
            assert (drain_data == ent.data)
               else report_mismatch($sformatf("drain_data %h, expected %h", drain_data, ent.data));
         end
         inflight = int'(isldst_dc1) + int'(ldst_dc2) + int'(ldst_dc3);
         exp_full = ((model_q.size() + inflight) >= `STBUF_DEPTH);
         assert (stbuf_full == exp_full)
            else report_mismatch($sformatf("stbuf_full %0b, expected %0b", stbuf_full, exp_full));
         assert (stbuf_empty == (model_q.size() == 0))
            else report_mismatch($sformatf("stbuf_empty %0b with %0d entries",
                                           stbuf_empty, model_q.size()));
         assert (fwd_byteen_dc3 == exp_fwd_be)
            else report_mismatch($sformatf("fwd_byteen_dc3 %h, expected %h",
                                           fwd_byteen_dc3, exp_fwd_be));
         assert (fwd_data_dc3 == exp_fwd_data)
            else report_mismatch($sformatf("fwd_data_dc3 %h, expected %h",
                                           fwd_data_dc3, exp_fwd_data));

         // forwarding for next cycle walks oldest first then the dc3 store
         nbe   = '0;
         ndata = '0;
         if (load_cmpen_dc2) begin
            foreach (model_q[i]) begin
               if ((model_q[i].st != 2'd2) && same_word(model_q[i].addr, load_addr_dc2)) begin
                  ndata = overlay(ndata, model_q[i].data, model_q[i].be);
                  nbe   = nbe | model_q[i].be;
               end
            end
            if (store_valid_dc3 && same_word(store_addr_dc3, load_addr_dc2)) begin
               ndata = overlay(ndata, store_data_dc3, lane_mask(store_size_dc3, store_addr_dc3));
               nbe   = nbe | lane_mask(store_size_dc3, store_addr_dc3);
            end
         end
         exp_fwd_be   = nbe;
         exp_fwd_data = ndata;

         // head leaves on drain_done, or on its own when flushed
         if (model_q.size() > 0) begin
            ent = model_q[0];
            if (((ent.st == 2'd1) && drain_done) || (ent.st == 2'd2)) begin
               void'(model_q.pop_front());
               if (ent.st == 2'd1) begin
                  n_drained++;
               end else begin
                  n_flushed++;
               end
            end
         end
         if (p2_v) begin
            for (int i = 0; i < model_q.size(); i++) begin
               ent = model_q[i];
               if (ent.seq == p2_seq) begin
                  ent.st     = commit_dc5 ? 2'd1 : 2'd2;
                  model_q[i] = ent;
               end
            end
         end
         if (store_valid_dc3) begin
            ent.seq  = store_seq;
            ent.addr = store_addr_dc3;
            ent.be   = lane_mask(store_size_dc3, store_addr_dc3);
            ent.data = store_data_dc3;
            ent.st   = 2'd0;
            model_q.push_back(ent);
         end
         p2_v   = p1_v;
         p2_seq = p1_seq;
         p1_v   = store_valid_dc3;
         p1_seq = store_seq;
         if (store_valid_dc3) begin
            store_seq++;
         end
      end
      full_seen = stbuf_full;
   end

   // head payload holds under back-pressure
   assert property (@(posedge clk) disable iff (!rst_n)
      (drain_req && !drain_done) |=> (drain_req && $stable(drain_addr) &&
                                      $stable(drain_byteen) && $stable(drain_data)))
      else report_mismatch("drain outputs changed while drain_done was low");

   initial begin : watchdog
      #(WDOG_CYCLES * 10);
      $display("timeout: run did not finish within %0d cycles", WDOG_CYCLES);
      print_summary();
      $display("*** TEST FAILED ***");
      $finish;
   end

   // -------------------------------------------------------------------------
   // main sequence
   // -------------------------------------------------------------------------
   initial begin
      void'($urandom(95));
      for (int i = 1; i <= 3; i++) begin
         pk[i] = 2'd0;
         pa[i] = '0;
         ps[i] = sz_byte;
         pd[i] = '0;
      end
      rst_n           <= 1'b0;
      store_valid_dc3 <= 1'b0;
      store_addr_dc3  <= '0;
      store_size_dc3  <= sz_byte;
      store_data_dc3  <= '0;
      isldst_dc1      <= 1'b0;
      ldst_dc2        <= 1'b0;
      ldst_dc3        <= 1'b0;
      commit_dc5      <= 1'b0;
      load_cmpen_dc2  <= 1'b0;
      load_addr_dc2   <= '0;
      drain_done      <= 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      assert (stbuf_empty && !drain_req && !drain_flushed && !stbuf_full)
         else report_mismatch("flags not at their reset values");

      while (n_issued < NUM_STORES) begin
         @(posedge clk);
         drive_cycle(1'b1);
      end
      // let the pipe and the buffer run dry
      while ((model_q.size() != 0) || (pk[1] != 2'd0) || (pk[2] != 2'd0) || (pk[3] != 2'd0)) begin
         @(posedge clk);
         drive_cycle(1'b0);
      end
      repeat (4) begin
         @(posedge clk);
         drive_cycle(1'b0);
      end

      print_summary();
      if (n_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
stbuf_pkg.sv
stbuf_alloc.sv
stbuf_entries.sv
stbuf_fwd.sv
stbuf_top.sv
tb_stbuf.sv

// File: run.sh
#!/usr/bin/env bash
# builds the store buffer testbench with Verilator and runs it

rm -rf obj_dir build.log sim.log \
   && verilator --binary --timing --assert --top-module tb_stbuf -f files.f \
      -o sim_stbuf > build.log 2>&1 \
   && ./obj_dir/sim_stbuf > sim.log 2>&1 \
   && grep -qF "*** TEST PASSED ***" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }
